/* logic/axil_slave_port.sv */
// ----------------------------------------
// AXI4-Lite peripheral slave port
// ----------------------------------------
module axil_slave_port
	import soc_bus_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  addr_t       awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  data_t       wdata,
	input  logic        wvalid,
	output logic        wready,
	output resp_t       bresp,
	output logic        bvalid,
	input  logic        bready,
	input  addr_t       araddr,
	input  logic        arvalid,
	output logic        arready,
	output data_t       rdata,
	output resp_t       rresp,
	output logic        rvalid,
	input  logic        rready,
	output reg_req_t    req,
	output logic        req_valid,
	output periph_sel_t sel,
	input  reg_rsp_t    timer_rsp,
	input  reg_rsp_t    spi_rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_RESP
	} state_e;

	state_e      state;
	logic        wr_go;
	logic        rd_go;
	addr_t       dec_addr;
	region_e     region;
	periph_sel_t dec_sel;
	reg_rsp_t    sel_rsp;
	resp_t       resp_q;

	// ----------------------------------------
	// handshake and decode

	// write wins over a read in the same cycle
	assign wr_go   = (state == ST_IDLE) && awvalid && wvalid;
	assign rd_go   = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);
	assign awready = wr_go;
	assign wready  = wr_go;
	assign arready = rd_go;

	assign dec_addr = wr_go ? awaddr : araddr;
	assign region   = region_e'(dec_addr[15:14]);

	always_comb begin
		dec_sel = '0;
		case (region)
			REGION_TIMER: dec_sel.timer = 1'b1;
			REGION_SPI:   dec_sel.spi   = 1'b1;
			default:      dec_sel       = '0;
		endcase
	end

	// unmapped region answers with its own error
	always_comb begin
		if (sel.timer) begin
			sel_rsp = timer_rsp;
		end else if (sel.spi) begin
			sel_rsp = spi_rsp;
		end else begin
			sel_rsp = '{rdata: '0, err: 1'b1};
		end
	end

	// ----------------------------------------
	// transaction FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			req_valid <= 1'b0;
			sel       <= '0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wr_go || rd_go) begin
						state     <= ST_WAIT;
						req_valid <= 1'b1;
						sel       <= dec_sel;
					end
				end
				// block registers its answer one edge after req_valid
				ST_WAIT: begin
					if (!req_valid) begin
						state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if ((req.write && bready) || (!req.write && rready)) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go || rd_go) begin
			req.write  <= wr_go;
			req.offset <= dec_addr[5:0];
			req.wdata  <= wdata;
		end
		if (state == ST_WAIT && !req_valid) begin
			rdata  <= sel_rsp.rdata;
			resp_q <= sel_rsp.err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign bvalid = (state == ST_RESP) && req.write;
	assign rvalid = (state == ST_RESP) && !req.write;
	assign bresp  = resp_q;
	assign rresp  = resp_q;

endmodule

/* logic/mtimer_core.sv */
// ----------------------------------------
// machine timer counter
// ----------------------------------------
module mtimer_core
	import periph_pkg::*;
#(
	parameter int CLK_MHZ = 27
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   dbg_halt,
	input  logic   mtime_wr,
	input  mtime_t mtime_wdata,
	input  mtime_t mtimecmp,
	output mtime_t mtime,
	output logic   timer_irq
);

	localparam int PW = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;
	localparam logic [PW-1:0] PRESC_LAST = PW'(CLK_MHZ - 1);

	logic [PW-1:0] presc;
	logic          tick;

	// one tick per microsecond, frozen under debug halt
	assign tick = !dbg_halt && (presc == PRESC_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
		end else if (mtime_wr || tick) begin
			// a new mtime value starts a full microsecond
			presc <= '0;
		end else if (!dbg_halt) begin
			presc <= presc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (mtime_wr) begin
			mtime <= mtime_wdata;
		end else if (tick) begin
			mtime <= mtime + 64'd1;
		end
	end

	assign timer_irq = (mtime >= mtimecmp);

endmodule

/* logic/mtimer_regs.sv */
// ----------------------------------------
// machine timer registers
// ----------------------------------------
module mtimer_regs
	import soc_bus_pkg::*;
	import periph_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_req_t req,
	input  logic     req_valid,
	input  logic     sel_timer,
	input  mtime_t   mtime,
	output reg_rsp_t rsp,
	output logic     mtime_wr,
	output mtime_t   mtime_wdata,
	output mtime_t   mtimecmp,
	output logic     soft_irq
);

	logic  acc;
	logic  wr;
	logic  msip;
	logic  known;
	data_t rd_word;

	assign acc = req_valid && sel_timer;
	assign wr  = acc && req.write;

	always_comb begin
		known   = 1'b1;
		rd_word = '0;
		case (req.offset)
			OFF_MTIME_LO:    rd_word = mtime[31:0];
			OFF_MTIME_HI:    rd_word = mtime[63:32];
			OFF_MTIMECMP_LO: rd_word = mtimecmp[31:0];
			OFF_MTIMECMP_HI: rd_word = mtimecmp[63:32];
			OFF_MSIP:        rd_word[MSIP_BIT] = msip;
			default:         known = 1'b0;
		endcase
	end

	// a half write keeps the other half of the running count
	assign mtime_wr = wr && (req.offset == OFF_MTIME_LO || req.offset == OFF_MTIME_HI);
	assign mtime_wdata = (req.offset == OFF_MTIME_HI) ?
		{req.wdata, mtime[31:0]} : {mtime[63:32], req.wdata};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= MTIMECMP_RESET;
			msip     <= 1'b0;
		end else if (wr) begin
			case (req.offset)
				OFF_MTIMECMP_LO: mtimecmp[31:0]  <= req.wdata;
				OFF_MTIMECMP_HI: mtimecmp[63:32] <= req.wdata;
				OFF_MSIP:        msip            <= req.wdata[MSIP_BIT];
				default:         ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			rsp.rdata <= req.write ? '0 : rd_word;
			rsp.err   <= !known;
		end
	end

	assign soft_irq = msip;

endmodule

/* logic/periph_pkg.sv */
// ----------------------------------------
// timer and SPI register map
// ----------------------------------------
package periph_pkg;

	typedef logic [63:0] mtime_t;
	typedef logic [7:0]  spi_byte_t;

	// machine timer offsets
	localparam logic [5:0] OFF_MTIME_LO    = 6'h00;
	localparam logic [5:0] OFF_MTIME_HI    = 6'h04;
	localparam logic [5:0] OFF_MTIMECMP_LO = 6'h08;
	localparam logic [5:0] OFF_MTIMECMP_HI = 6'h0C;
	localparam logic [5:0] OFF_MSIP        = 6'h10;

	// SD SPI offsets
	localparam logic [5:0] OFF_SPI_DATA   = 6'h00;
	localparam logic [5:0] OFF_SPI_STATUS = 6'h04;
	localparam logic [5:0] OFF_SPI_CTRL   = 6'h08;

	// no compare match until software sets mtimecmp
	localparam mtime_t MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

	// field positions
	localparam int MSIP_BIT        = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int CTRL_CS_BIT     = 0;

	localparam logic CS_N_RESET = 1'b1;

endpackage

/* logic/periph_top.sv */
// ----------------------------------------
// peripheral subsystem top
// ----------------------------------------
module periph_top
	import soc_bus_pkg::*;
	import periph_pkg::*;
#(
	parameter int CLK_MHZ = 27,
	parameter int SPI_DIV = 4
) (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t awaddr,
	input  logic  awvalid,
	output logic  awready,
	input  data_t wdata,
	input  logic  wvalid,
	output logic  wready,
	output resp_t bresp,
	output logic  bvalid,
	input  logic  bready,
	input  addr_t araddr,
	input  logic  arvalid,
	output logic  arready,
	output data_t rdata,
	output resp_t rresp,
	output logic  rvalid,
	input  logic  rready,
	input  logic  dbg_halt,
	output logic  timer_irq,
	output logic  soft_irq,
	output logic  sd_clk,
	output logic  sd_cmd,
	output logic  sd_cs_n,
	input  logic  sd_dat0
);

	reg_req_t    req;
	logic        req_valid;
	periph_sel_t sel;
	reg_rsp_t    timer_rsp;
	reg_rsp_t    spi_rsp;
	mtime_t      mtime;
	mtime_t      mtime_wdata;
	mtime_t      mtimecmp;
	logic        mtime_wr;
	logic        start;
	logic        busy;
	spi_byte_t   tx_byte;
	spi_byte_t   rx_byte;

	axil_slave_port port_u (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.req, .req_valid, .sel,
		.timer_rsp, .spi_rsp
	);

	// ----------------------------------------
	// machine timer

	mtimer_regs timer_regs_u (
		.clk, .rst_n,
		.req, .req_valid,
		.sel_timer (sel.timer),
		.mtime,
		.rsp       (timer_rsp),
		.mtime_wr, .mtime_wdata, .mtimecmp,
		.soft_irq
	);

	mtimer_core #(
		.CLK_MHZ (CLK_MHZ)
	) timer_core_u (
		.clk, .rst_n, .dbg_halt,
		.mtime_wr, .mtime_wdata, .mtimecmp,
		.mtime, .timer_irq
	);

	// ----------------------------------------
	// SD card SPI

	sd_spi_regs spi_regs_u (
		.clk, .rst_n,
		.req, .req_valid,
		.sel_spi (sel.spi),
		.busy, .rx_byte,
		.rsp     (spi_rsp),
		.start, .tx_byte,
		.cs_n    (sd_cs_n)
	);

	sd_spi_shifter #(
		.SPI_DIV (SPI_DIV)
	) spi_shift_u (
		.clk, .rst_n,
		.start, .tx_byte, .sd_dat0,
		.sd_clk, .sd_cmd,
		.busy, .rx_byte
	);

endmodule

/* logic/sd_spi_regs.sv */
// ----------------------------------------
// SD SPI registers
// ----------------------------------------
module sd_spi_regs
	import soc_bus_pkg::*;
	import periph_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_req_t  req,
	input  logic      req_valid,
	input  logic      sel_spi,
	input  logic      busy,
	input  spi_byte_t rx_byte,
	output reg_rsp_t  rsp,
	output logic      start,
	output spi_byte_t tx_byte,
	output logic      cs_n
);

	logic  acc;
	logic  err;
	data_t rd_word;

	assign acc = req_valid && sel_spi;

	// DATA write only launches when the shifter is idle
	assign start   = acc && req.write && (req.offset == OFF_SPI_DATA) && !busy;
	assign tx_byte = req.wdata[7:0];

	always_comb begin
		err     = 1'b0;
		rd_word = '0;
		case (req.offset)
			OFF_SPI_DATA: begin
				rd_word[7:0] = rx_byte;
				err          = req.write && busy;
			end
			OFF_SPI_STATUS: rd_word[STATUS_BUSY_BIT] = busy;
			OFF_SPI_CTRL:   rd_word[CTRL_CS_BIT] = cs_n;
			default:        err = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n <= CS_N_RESET;
		end else if (acc && req.write && req.offset == OFF_SPI_CTRL) begin
			cs_n <= req.wdata[CTRL_CS_BIT];
		end
	end

	always_ff @(posedge clk) begin
		if (acc) begin
			rsp.rdata <= req.write ? '0 : rd_word;
			rsp.err   <= err;
		end
	end

endmodule

/* logic/sd_spi_shifter.sv */
// ----------------------------------------
// SPI mode 0 byte shifter
// ----------------------------------------
module sd_spi_shifter
	import periph_pkg::*;
#(
	parameter int SPI_DIV = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  spi_byte_t tx_byte,
	input  logic      sd_dat0,
	output logic      sd_clk,
	output logic      sd_cmd,
	output logic      busy,
	output spi_byte_t rx_byte
);

	localparam int DW = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
	localparam logic [DW-1:0] DIV_LAST = DW'(SPI_DIV - 1);

	logic [DW-1:0] div_cnt;
	logic [2:0]    bit_cnt;
	logic          toggle;
	spi_byte_t     tx_sh;

	// sd_clk flips every SPI_DIV cycles
	assign toggle = busy && (div_cnt == DIV_LAST);

	// msb leads while sd_clk is low, line idles high
	assign sd_cmd = busy ? tx_sh[7] : 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			sd_clk  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (start) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (toggle) begin
			div_cnt <= '0;
			sd_clk  <= !sd_clk;
			// falling edge closes a bit
			if (sd_clk) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					busy <= 1'b0;
				end
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			tx_sh <= tx_byte;
		end else if (toggle && sd_clk) begin
			tx_sh <= {tx_sh[6:0], 1'b0};
		end
		// sample on the rising sd_clk
		if (toggle && !sd_clk) begin
			rx_byte <= {rx_byte[6:0], sd_dat0};
		end
	end

endmodule

/* logic/soc_bus_pkg.sv */
// ----------------------------------------
// peripheral bus types and region map
// ----------------------------------------
package soc_bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// region comes from address bits 15:14
	typedef enum logic [1:0] {
		REGION_TIMER  = 2'd0,
		REGION_SPI    = 2'd1,
		REGION_UNMAP2 = 2'd2,
		REGION_UNMAP3 = 2'd3
	} region_e;

	typedef struct packed {
		logic timer;
		logic spi;
	} periph_sel_t;

	// one register access, broadcast to all blocks
	typedef struct packed {
		logic       write;
		logic [5:0] offset;
		data_t      wdata;
	} reg_req_t;

	typedef struct packed {
		data_t rdata;
		logic  err;
	} reg_rsp_t;

endpackage

/* src.f */
+incdir+tb
logic/soc_bus_pkg.sv
logic/periph_pkg.sv
logic/axil_slave_port.sv
logic/mtimer_regs.sv
logic/mtimer_core.sv
logic/sd_spi_regs.sv
logic/sd_spi_shifter.sv
logic/periph_top.sv
tb/tb_periph_top.sv

/* tb/tb_periph_tasks.svh */
// ----------------------------------------
// bus driver, checks and directed tests
// ----------------------------------------
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

function automatic addr_t timer_reg(input logic [5:0] off);
	return TIMER_BASE | addr_t'(off);
endfunction

function automatic addr_t spi_reg(input logic [5:0] off);
	return SPI_BASE | addr_t'(off);
endfunction

task automatic stop_run();
	$display("FAIL: see errors above");
	$fatal(1, "run stopped at the first error");
endtask

// ----------------------------------------
// compare tasks

task automatic compare_data(input data_t got, input data_t exp, input string what);
	if (got !== exp) begin
		$display("FAILED at %0d ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic compare_resp(input resp_t got, input resp_t exp, input string what);
	if (got !== exp) begin
		$display("FAILED at %0d ns: %s, got resp %b, expected %b", $time, what, got, exp);
		stop_run();
	end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		$display("FAILED at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
		stop_run();
	end
endtask

// ----------------------------------------
// AXI4-Lite driver

task automatic send_write(input addr_t addr, input data_t data);
	@(negedge clk);
	awaddr  = addr;
	wdata   = data;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	#1;
	while (!(awready && wready)) begin
		@(negedge clk);
		#1;
	end
	// handshake lands on the coming rising edge
	@(negedge clk);
	awvalid = 1'b0;
	wvalid  = 1'b0;
endtask

task automatic take_write_resp(output resp_t resp);
	bready = 1'b1;
	while (!bvalid) @(negedge clk);
	resp = bresp;
	@(negedge clk);
	bready = 1'b0;
endtask

task automatic send_read(input addr_t addr);
	@(negedge clk);
	araddr  = addr;
	arvalid = 1'b1;
	#1;
	while (!arready) begin
		@(negedge clk);
		#1;
	end
	@(negedge clk);
	arvalid = 1'b0;
endtask

task automatic take_read_resp(output data_t got, output resp_t resp);
	rready = 1'b1;
	while (!rvalid) @(negedge clk);
	got  = rdata;
	resp = rresp;
	@(negedge clk);
	rready = 1'b0;
endtask

task automatic axi_write(input addr_t addr, input data_t data, output resp_t resp);
	send_write(addr, data);
	take_write_resp(resp);
endtask

task automatic axi_read(input addr_t addr, output data_t got, output resp_t resp);
	send_read(addr);
	take_read_resp(got, resp);
endtask

task automatic write_ok(input addr_t addr, input data_t data);
	resp_t resp;
	axi_write(addr, data, resp);
	compare_resp(resp, RESP_OKAY, "write response");
endtask

task automatic read_ok(input addr_t addr, output data_t got);
	resp_t resp;
	axi_read(addr, got, resp);
	compare_resp(resp, RESP_OKAY, "read response");
endtask

task automatic wait_spi_idle();
	data_t st;
	do begin
		read_ok(spi_reg(OFF_SPI_STATUS), st);
	end while (st[STATUS_BUSY_BIT]);
endtask

// ----------------------------------------
// directed tests

task automatic test_reset_values();
	data_t rd;
	compare_bit(bvalid, 1'b0, "bvalid after reset");
	compare_bit(rvalid, 1'b0, "rvalid after reset");
	compare_bit(awready, 1'b0, "awready after reset");
	compare_bit(wready, 1'b0, "wready after reset");
	compare_bit(arready, 1'b0, "arready after reset");
	compare_bit(timer_irq, 1'b0, "timer_irq after reset");
	compare_bit(soft_irq, 1'b0, "soft_irq after reset");
	compare_bit(sd_cs_n, 1'b1, "sd_cs_n after reset");
	compare_bit(sd_clk, 1'b0, "sd_clk after reset");
	compare_bit(sd_cmd, 1'b1, "sd_cmd after reset");
	read_ok(timer_reg(OFF_MTIMECMP_LO), rd);
	compare_data(rd, 32'hFFFF_FFFF, "mtimecmp low after reset");
endtask

task automatic test_halt_freeze();
	data_t lo;
	data_t hi;
	data_t rd;
	lo = $urandom();
	// top bit clear leaves headroom for the compare test
	hi = $urandom() & 32'h7FFF_FFFF;
	@(negedge clk);
	dbg_halt = 1'b1;
	write_ok(timer_reg(OFF_MTIME_LO), lo);
	write_ok(timer_reg(OFF_MTIME_HI), hi);
	read_ok(timer_reg(OFF_MTIME_LO), rd);
	compare_data(rd, lo, "mtime low readback under halt");
	read_ok(timer_reg(OFF_MTIME_HI), rd);
	compare_data(rd, hi, "mtime high readback under halt");
	repeat (50) @(negedge clk);
	read_ok(timer_reg(OFF_MTIME_LO), rd);
	compare_data(rd, lo, "mtime low after 50 halted cycles");
	read_ok(timer_reg(OFF_MTIME_HI), rd);
	compare_data(rd, hi, "mtime high after 50 halted cycles");
endtask

task automatic test_compare_irq();
	data_t  lo;
	data_t  hi;
	data_t  rd;
	mtime_t cmp;
	int     waited;
	// still halted, so both halves belong together
	read_ok(timer_reg(OFF_MTIME_LO), lo);
	read_ok(timer_reg(OFF_MTIME_HI), hi);
	cmp = {hi, lo} + mtime_t'(TICKS_AHEAD);
	write_ok(timer_reg(OFF_MTIMECMP_HI), cmp[63:32]);
	write_ok(timer_reg(OFF_MTIMECMP_LO), cmp[31:0]);
	compare_bit(timer_irq, 1'b0, "timer_irq before the compare point");
	@(negedge clk);
	dbg_halt = 1'b0;
	waited = 0;
	while (!timer_irq) begin
		if (waited == 2 * TICKS_AHEAD * TB_CLK_MHZ) begin
			$display("timer_irq did not rise within %0d cycles of halt release", waited);
			stop_run();
		end else begin
			@(negedge clk);
			waited++;
		end
	end
	compare_bit(waited >= (TICKS_AHEAD - 1) * TB_CLK_MHZ, 1'b1, "timer_irq rose too early");
	// freeze again for a coherent 64-bit read
	@(negedge clk);
	dbg_halt = 1'b1;
	read_ok(timer_reg(OFF_MTIME_LO), lo);
	read_ok(timer_reg(OFF_MTIME_HI), hi);
	compare_bit({hi, lo} >= cmp, 1'b1, "mtime at least mtimecmp");
	@(negedge clk);
	dbg_halt = 1'b0;
	write_ok(timer_reg(OFF_MTIMECMP_HI), 32'hFFFF_FFFF);
	write_ok(timer_reg(OFF_MTIMECMP_LO), 32'hFFFF_FFFF);
	compare_bit(timer_irq, 1'b0, "timer_irq after mtimecmp set to all ones");
	write_ok(timer_reg(OFF_MSIP), 32'h1);
	compare_bit(soft_irq, 1'b1, "soft_irq after msip set");
	read_ok(timer_reg(OFF_MSIP), rd);
	compare_data(rd, 32'h1, "msip readback");
	write_ok(timer_reg(OFF_MSIP), 32'h0);
	compare_bit(soft_irq, 1'b0, "soft_irq after msip clear");
endtask

task automatic test_spi_loopback();
	spi_byte_t b;
	data_t     rd;
	b = spi_byte_t'($urandom());
	write_ok(spi_reg(OFF_SPI_CTRL), 32'h0);
	compare_bit(sd_cs_n, 1'b0, "sd_cs_n after CTRL write of 0");
	write_ok(spi_reg(OFF_SPI_DATA), {24'h0, b});
	wait_spi_idle();
	read_ok(spi_reg(OFF_SPI_DATA), rd);
	compare_data(rd, {24'h0, b}, "looped back SPI byte");
endtask

task automatic test_error_responses();
	data_t     rd;
	resp_t     resp;
	spi_byte_t first;
	axi_read(UNMAP_BASE | 16'h0010, rd, resp);
	compare_resp(resp, RESP_SLVERR, "read from unmapped region");
	compare_data(rd, 32'h0, "rdata from unmapped region");
	first = spi_byte_t'($urandom());
	write_ok(spi_reg(OFF_SPI_DATA), {24'h0, first});
	axi_write(spi_reg(OFF_SPI_DATA), {24'h0, ~first}, resp);
	compare_resp(resp, RESP_SLVERR, "DATA write while busy");
	wait_spi_idle();
	read_ok(spi_reg(OFF_SPI_DATA), rd);
	compare_data(rd, {24'h0, first}, "byte of the transfer in progress");
endtask

task automatic test_back_pressure();
	data_t val;
	data_t rd;
	resp_t resp;
	val = $urandom();
	send_write(timer_reg(OFF_MTIMECMP_LO), val);
	while (!bvalid) @(negedge clk);
	// new traffic offered while the response waits
	awaddr  = spi_reg(OFF_SPI_CTRL);
	wdata   = 32'h1;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	araddr  = timer_reg(OFF_MTIME_LO);
	arvalid = 1'b1;
	repeat (10) begin
		@(negedge clk);
		compare_bit(bvalid, 1'b1, "bvalid held under back-pressure");
		compare_bit(awready, 1'b0, "awready under back-pressure");
		compare_bit(wready, 1'b0, "wready under back-pressure");
		compare_bit(arready, 1'b0, "arready under back-pressure");
	end
	awvalid = 1'b0;
	wvalid  = 1'b0;
	arvalid = 1'b0;
	take_write_resp(resp);
	compare_resp(resp, RESP_OKAY, "write response after back-pressure");
	read_ok(timer_reg(OFF_MTIMECMP_LO), rd);
	compare_data(rd, val, "mtimecmp low after back-pressure");
	compare_bit(sd_cs_n, 1'b0, "offered CTRL write was not taken");
endtask

`endif

/* tb/tb_periph_top.sv */
// ----------------------------------------
// peripheral top testbench
// ----------------------------------------
module tb_periph_top
	import soc_bus_pkg::*;
	import periph_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TB_CLK_MHZ = 4;
	localparam int TB_SPI_DIV = 2;
	localparam int RNG_SEED   = 40225;

	// longest run is well under 1000 cycles
	localparam int CYCLE_LIMIT = 4000;

	// mtimecmp target distance in ticks
	localparam int TICKS_AHEAD = 20;

	localparam addr_t TIMER_BASE = 16'h0000;
	localparam addr_t SPI_BASE   = 16'h4000;
	localparam addr_t UNMAP_BASE = 16'h8000;

	logic  clk = 1'b0;
	logic  rst_n;
	addr_t awaddr;
	logic  awvalid;
	logic  awready;
	data_t wdata;
	logic  wvalid;
	logic  wready;
	resp_t bresp;
	logic  bvalid;
	logic  bready;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;
	logic  dbg_halt;
	logic  timer_irq;
	logic  soft_irq;
	logic  sd_clk;
	logic  sd_cmd;
	logic  sd_cs_n;
	logic  sd_dat0;

	int unsigned cycles = 0;

	periph_top #(
		.CLK_MHZ (TB_CLK_MHZ),
		.SPI_DIV (TB_SPI_DIV)
	) uut (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.dbg_halt, .timer_irq, .soft_irq,
		.sd_clk, .sd_cmd, .sd_cs_n, .sd_dat0
	);

	// card side loops MOSI back to MISO
	assign sd_dat0 = sd_cmd;

	// 8 ns period
	always #4 clk = ~clk;

	`include "tb_periph_tasks.svh"

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run exceeded %0d clock cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	// ----------------------------------------
	// test sequence

	initial begin
		void'($urandom(RNG_SEED));
		rst_n    = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		dbg_halt = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_reset_values();
		test_halt_freeze();
		test_compare_irq();
		test_spi_loopback();
		test_error_responses();
		test_back_pressure();

		$display("PASS: all tests");
		$finish;
	end

endmodule
